//--- verilog/spi_regfile_pkg.sv
// shared types for the spi register file; a 6 bit address allows at most 8 banks of 8 bytes
`default_nettype none

package spi_regfile_pkg;

   // ##############################
   // widths
   // ##############################

   typedef logic [7:0] reg_byte_t;      // one register byte
   typedef logic [5:0] reg_addr_t;      // command bits 5:0
   typedef logic [2:0] bank_index_t;    // upper address bits

   localparam int BANK_REGS = 8;        // registers per bank

   // ##############################
   // encodings
   // ##############################

   // command field, bits 7:6 of the first byte
   // codes 01 and 11 are unnamed and get ignored
   typedef enum logic [1:0]
   {
      CMD_WRITE = 2'b00,
      CMD_READ  = 2'b10
   } spi_cmd_e;

   // front end states
   typedef enum logic [1:0]
   {
      ST_CMD   = 2'b00,   // shifting command byte
      ST_WRITE = 2'b01,   // shifting write data
      ST_READ  = 2'b10,   // shifting read data out
      ST_DONE  = 2'b11    // idle until ss rises
   } spi_state_e;

endpackage

`default_nettype wire

//--- verilog/spi_slave_io.sv
// spi mode 0 slave front end; ss is the async reset, one command byte plus one data byte per frame
`timescale 1ns/1ps
`default_nettype none

module spi_slave_io
(
   input  logic                       sclk,      // spi clock
   input  logic                       ss,        // slave select, high = reset
   input  logic                       mosi,      // serial in
   output logic                       miso,      // serial out
   output logic                       wr_en,     // one cycle write strobe
   output spi_regfile_pkg::reg_addr_t wr_addr,   // latched at edge 8
   output spi_regfile_pkg::reg_byte_t wr_data,   // valid with wr_en
   output spi_regfile_pkg::reg_addr_t rd_addr,   // live command address
   input  spi_regfile_pkg::reg_byte_t rd_data    // from read selector
);

   // ##############################
   // counter limits
   // ##############################

   // bit_cnt holds the number of edges seen so far in this frame
   localparam logic [4:0] CNT_CMD  = 5'd7;    // edge 8 is next
   localparam logic [4:0] CNT_DATA = 5'd15;   // edge 16 is next
   localparam logic [4:0] CNT_MAX  = 5'd16;   // saturate here

   spi_regfile_pkg::spi_state_e state;
   spi_regfile_pkg::reg_byte_t  rx_shift;   // receive shifter
   spi_regfile_pkg::reg_byte_t  tx_shift;   // transmit shifter
   logic [4:0]                  bit_cnt;
   logic [1:0]                  cmd_code;   // opcode of byte in flight
   logic                        cmd_edge;   // next edge completes command
   logic                        data_edge;  // next edge completes data byte
   logic                        load_tx;

   // ##############################
   // receive side
   // ##############################

   // msb first, new bit enters at the bottom
   always_ff @(posedge sclk or posedge ss)
   begin
      if (ss)
         rx_shift <= '0;
      else
         rx_shift <= {rx_shift[6:0], mosi};
   end

   // edge counter, stops at 16 so trailing bits are ignored
   always_ff @(posedge sclk or posedge ss)
   begin
      if (ss)
         bit_cnt <= '0;
      else if (bit_cnt != CNT_MAX)
         bit_cnt <= bit_cnt + 5'd1;
   end

   assign cmd_code  = rx_shift[6:5];              // bits 7:6 once mosi lands
   assign cmd_edge  = (state == spi_regfile_pkg::ST_CMD) && (bit_cnt == CNT_CMD);
   assign data_edge = (bit_cnt == CNT_DATA);

   // address completes with the current mosi bit
   assign rd_addr = {rx_shift[4:0], mosi};

   // ##############################
   // state machine
   // ##############################

   always_ff @(posedge sclk or posedge ss)
   begin
      if (ss)
         state <= spi_regfile_pkg::ST_CMD;
      else
      begin
         case (state)
            spi_regfile_pkg::ST_CMD:
            begin
               if (cmd_edge)
               begin
                  case (cmd_code)
                     spi_regfile_pkg::CMD_WRITE: state <= spi_regfile_pkg::ST_WRITE;
                     spi_regfile_pkg::CMD_READ:  state <= spi_regfile_pkg::ST_READ;
                     default:                    state <= spi_regfile_pkg::ST_DONE;  // 01, 11
                  endcase
               end
            end
            spi_regfile_pkg::ST_WRITE,
            spi_regfile_pkg::ST_READ:
            begin
               if (data_edge)
                  state <= spi_regfile_pkg::ST_DONE;
            end
            default:
               state <= spi_regfile_pkg::ST_DONE;   // wait for ss
         endcase
      end
   end

   // address register, payload only
   always_ff @(posedge sclk)
   begin
      if (cmd_edge)
         wr_addr <= rd_addr;
   end

   // ##############################
   // register file side
   // ##############################

   // strobe covers the cycle ending at edge 16
   assign wr_en   = (state == spi_regfile_pkg::ST_WRITE) && data_edge;
   assign wr_data = {rx_shift[6:0], mosi};

   // load at edge 8 for reads only
   assign load_tx = cmd_edge && (cmd_code == spi_regfile_pkg::CMD_READ);

   always_ff @(posedge sclk or posedge ss)
   begin
      if (ss)
         tx_shift <= '0;                        // miso low while deselected
      else if (load_tx)
         tx_shift <= rd_data;
      else
         tx_shift <= {tx_shift[6:0], 1'b0};    // zeros trail the byte
   end

   assign miso = tx_shift[7];

   // ##############################
   // checks
   // ##############################

   // a write strobe closes a frame whose command decoded as a write
   a_wr_en_in_write : assert property (
      @(posedge sclk) disable iff (ss)
      wr_en |-> $past(cmd_edge, 8) && ($past(cmd_code, 8) == spi_regfile_pkg::CMD_WRITE)
   );

   // counter stays inside the window of the current state
   a_cnt_limit : assert property (
      @(posedge sclk) disable iff (ss)
      ((state != spi_regfile_pkg::ST_CMD) || (bit_cnt <= CNT_CMD)) &&
      (((state != spi_regfile_pkg::ST_WRITE) && (state != spi_regfile_pkg::ST_READ)) ||
       ((bit_cnt > CNT_CMD) && (bit_cnt <= CNT_DATA)))
   );

endmodule

`default_nettype wire

//--- verilog/spi_reg_bank.sv
// eight byte registers with no reset; contents are undefined until written
`timescale 1ns/1ps
`default_nettype none

module spi_reg_bank
#(
   parameter int BANK_ID = 0                     // matched against addr 5:3
)
(
   input  logic                                       sclk,
   input  logic                                       wr_en,     // from front end
   input  spi_regfile_pkg::reg_addr_t                 wr_addr,
   input  spi_regfile_pkg::reg_byte_t                 wr_data,
   output logic [spi_regfile_pkg::BANK_REGS*8-1:0]    bank_regs  // reg 0 in low byte
);

   localparam spi_regfile_pkg::bank_index_t MY_BANK =
      spi_regfile_pkg::bank_index_t'(BANK_ID);

   spi_regfile_pkg::reg_byte_t regs [spi_regfile_pkg::BANK_REGS];

   logic       bank_hit;   // strobe aimed at this bank
   logic [2:0] reg_sel;    // register within bank

   // ##############################
   // write decode
   // ##############################

   assign bank_hit = wr_en && (wr_addr[5:3] == MY_BANK);
   assign reg_sel  = wr_addr[2:0];

   always_ff @(posedge sclk)
   begin
      if (bank_hit)
         regs[reg_sel] <= wr_data;
   end

   // ##############################
   // flat read-out
   // ##############################

   for (genvar r = 0; r < spi_regfile_pkg::BANK_REGS; r++)
   begin : g_flat
      assign bank_regs[r*8 +: 8] = regs[r];   // byte r
   end

   // data arriving from the front end must be clean when stored
   a_wr_data_known : assert property (
      @(posedge sclk)
      bank_hit |-> !$isunknown(wr_data)
   );

endmodule

`default_nettype wire

//--- verilog/spi_read_select.sv
// read mux over all banks; addresses at NUM_BANKS*8 and above read as zero
`timescale 1ns/1ps
`default_nettype none

module spi_read_select
#(
   parameter int NUM_BANKS = 4                   // 1 to 8
)
(
   input  logic                                                 sclk,      // for checks
   input  spi_regfile_pkg::reg_addr_t                           rd_addr,
   input  logic [NUM_BANKS*spi_regfile_pkg::BANK_REGS*8-1:0]    all_regs,  // bank 0 lowest
   output spi_regfile_pkg::reg_byte_t                           rd_data
);

   localparam int NUM_REGS = NUM_BANKS * spi_regfile_pkg::BANK_REGS;

   spi_regfile_pkg::reg_byte_t  byte_at [NUM_REGS];   // unpacked view
   spi_regfile_pkg::bank_index_t sel_bank;
   logic                        in_range;

   // ##############################
   // unpack
   // ##############################

   for (genvar i = 0; i < NUM_REGS; i++)
   begin : g_unpack
      assign byte_at[i] = all_regs[i*8 +: 8];
   end

   // ##############################
   // select
   // ##############################

   assign sel_bank = rd_addr[5:3];
   assign in_range = (sel_bank < NUM_BANKS);   // same as rd_addr < NUM_REGS

   always_comb
   begin
      rd_data = '0;                              // out of range reads zero
      if (in_range)
      begin
         for (int i = 0; i < NUM_REGS; i++)
         begin
            if (rd_addr == i[5:0])
               rd_data = byte_at[i];
         end
      end
   end

   // once every register holds data an in-range read must come through clean
   // before that, unwritten registers are X
   a_rd_known : assert property (
      @(posedge sclk)
      (!$isunknown(rd_addr) && in_range && !$isunknown(all_regs)) |-> !$isunknown(rd_data)
   );

endmodule

`default_nettype wire

//--- verilog/spi_regfile_top.sv
// spi register file top; NUM_BANKS from 1 to 8, sclk is the only clock and ss resets the front end
`timescale 1ns/1ps
`default_nettype none

module spi_regfile_top
#(
   parameter int NUM_BANKS = 4                   // banks of 8 bytes
)
(
   input  logic sclk,
   input  logic ss,        // active high reset and deselect
   input  logic mosi,
   output logic miso
);

   localparam int BANK_W = spi_regfile_pkg::BANK_REGS * 8;   // bits per bank

   logic                        wr_en;
   spi_regfile_pkg::reg_addr_t  wr_addr;
   spi_regfile_pkg::reg_byte_t  wr_data;
   spi_regfile_pkg::reg_addr_t  rd_addr;
   spi_regfile_pkg::reg_byte_t  rd_data;
   logic [NUM_BANKS*BANK_W-1:0] all_regs;   // every bank, flat

   if ((NUM_BANKS < 1) || (NUM_BANKS > 8))
   begin : g_bad_banks
      $error("NUM_BANKS must be 1 to 8");
   end

   // ##############################
   // front end
   // ##############################

   spi_slave_io spi_slave_io_inst
   (
      .sclk    (sclk),
      .ss      (ss),
      .mosi    (mosi),
      .miso    (miso),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

   // ##############################
   // storage and read path
   // ##############################

   for (genvar g = 0; g < NUM_BANKS; g++)
   begin : g_bank
      spi_reg_bank #(.BANK_ID(g)) spi_reg_bank_inst
      (
         .sclk      (sclk),
         .wr_en     (wr_en),     // broadcast, bank decodes
         .wr_addr   (wr_addr),
         .wr_data   (wr_data),
         .bank_regs (all_regs[g*BANK_W +: BANK_W])
      );
   end

   spi_read_select #(.NUM_BANKS(NUM_BANKS)) spi_read_select_inst
   (
      .sclk     (sclk),
      .rd_addr  (rd_addr),
      .all_regs (all_regs),
      .rd_data  (rd_data)
   );

endmodule

`default_nettype wire

//--- include/spi_tb_tasks.svh
// include inside the testbench module after sclk, ss, mosi, miso and int error_count are declared
`ifndef SPI_TB_TASKS_SVH
`define SPI_TB_TASKS_SVH

// ##############################
// bit level
// ##############################

// call 2 ns after a rising edge; returns at the same point after the last bit
task automatic spi_shift_bits(input spi_regfile_pkg::reg_byte_t tx_byte, input int nbits,
                              output spi_regfile_pkg::reg_byte_t rx_byte);
   rx_byte = '0;
   for (int i = 7; i > 7 - nbits; i--)
   begin
      mosi = tx_byte[i];               // msb first
      @(negedge sclk);
      rx_byte = {rx_byte[6:0], miso};  // sample before the rising edge
      @(posedge sclk);
      #2;
   end
endtask

// one full frame; abort leaves ss low only through edge 12
task automatic spi_frame(input logic [1:0] op, input spi_regfile_pkg::reg_addr_t addr,
                         input spi_regfile_pkg::reg_byte_t data, input bit abort,
                         output spi_regfile_pkg::reg_byte_t rx_byte);
   spi_regfile_pkg::reg_byte_t dummy;
   ss = 1'b0;
   spi_shift_bits({op, addr}, 8, dummy);
   spi_shift_bits(data, abort ? 4 : 8, rx_byte);
   ss = 1'b1;
   mosi = 1'b0;
   repeat (2) @(posedge sclk);         // gap between frames
   #2;
endtask

// ##############################
// transactions
// ##############################

task automatic spi_write(input spi_regfile_pkg::reg_addr_t addr,
                         input spi_regfile_pkg::reg_byte_t data, input bit abort);
   spi_regfile_pkg::reg_byte_t unused;
   spi_frame(spi_regfile_pkg::CMD_WRITE, addr, data, abort, unused);
endtask

task automatic spi_read(input spi_regfile_pkg::reg_addr_t addr,
                        output spi_regfile_pkg::reg_byte_t data);
   spi_frame(spi_regfile_pkg::CMD_READ, addr, 8'h00, 1'b0, data);
endtask

task automatic check_byte(input string name, input spi_regfile_pkg::reg_byte_t expected,
                          input spi_regfile_pkg::reg_byte_t actual);
   if (actual !== expected)
   begin
      $display("ERROR %s expected %02h actual %02h", name, expected, actual);
      error_count++;
   end
endtask

`endif

//--- verification/tb_spi_regfile.sv
// runs from the project root to find the test data file; model assumes NUM_BANKS 4 and 64 addresses
`timescale 1ns/1ps
`default_nettype none

module tb_spi_regfile;

   localparam int NUM_BANKS    = 4;
   localparam int NUM_REGS     = NUM_BANKS * spi_regfile_pkg::BANK_REGS;
   localparam int RESET_CYCLES = 16;
   localparam int FRAME_CYCLES = 18;    // 16 bits plus the ss gap

   logic sclk;
   logic ss;
   logic mosi;
   logic miso;
   int   error_count = 0;
   int   cycle_count = 0;
   int   cycle_limit = 0;
   bit   limit_ready = 1'b0;              // limit known once file is loaded

   spi_regfile_pkg::reg_byte_t model [64];   // expected register contents

   // one entry per data line
   logic [1:0]                 op_q [$];
   spi_regfile_pkg::reg_addr_t addr_q [$];
   spi_regfile_pkg::reg_byte_t data_q [$];
   bit                         abort_q [$];
   bit                         check_q [$];
   spi_regfile_pkg::reg_byte_t expect_q [$];

   `include "spi_tb_tasks.svh"

   spi_regfile_top #(.NUM_BANKS(NUM_BANKS)) spi_regfile_top_inst
   (
      .sclk (sclk),
      .ss   (ss),
      .mosi (mosi),
      .miso (miso)
   );

   // ##############################
   // clock and watchdog
   // ##############################

   initial
   begin
      sclk = 1'b0;
      forever #20 sclk = ~sclk;          // 40 ns period
   end

   always @(posedge sclk)
      cycle_count <= cycle_count + 1;

   initial
   begin
      wait (limit_ready);
      while (cycle_count < cycle_limit)
         @(posedge sclk);
      $display("simulation timed out before all transactions finished");
      $display("SOME TESTS FAILED");
      $finish;
   end

   // ##############################
   // model and file
   // ##############################

   // out of range reads give zero
   function automatic spi_regfile_pkg::reg_byte_t model_read(input spi_regfile_pkg::reg_addr_t a);
      return (int'(a) < NUM_REGS) ? model[a] : 8'h00;
   endfunction

   task automatic load_testdata(output bit ok);
      int    fd;
      int    cnt;
      int    op, addr, data, abort, chk, expv;
      string line;
      ok = 1'b0;
      fd = $fopen("verification/spi_regfile_testdata.txt", "r");
      if (fd == 0)
         return;
      while (!$feof(fd))
      begin
         line = "";
         void'($fgets(line, fd));
         if ((line.len() > 1) && (line.getc(0) != "#"))   // skip blanks and column notes
         begin
            cnt = $sscanf(line, "%h %h %h %h %h %h", op, addr, data, abort, chk, expv);
            if (cnt == 6)
            begin
               op_q.push_back(op[1:0]);
               addr_q.push_back(addr[5:0]);
               data_q.push_back(data[7:0]);
               abort_q.push_back(abort[0]);
               check_q.push_back(chk[0]);
               expect_q.push_back(expv[7:0]);
            end
         end
      end
      $fclose(fd);
      ok = 1'b1;
   endtask

   task automatic run_entry(input int n);
      spi_regfile_pkg::reg_byte_t rx;
      string                      name;
      name = $sformatf("entry %0d addr %02h", n, addr_q[n]);
      case (op_q[n])
         2'b00:
         begin
            spi_write(addr_q[n], data_q[n], abort_q[n]);
            if (!abort_q[n] && (int'(addr_q[n]) < NUM_REGS))   // abandoned or out of range
               model[addr_q[n]] = data_q[n];
         end
         2'b10:
         begin
            spi_read(addr_q[n], rx);
            check_byte({name, " model"}, model_read(addr_q[n]), rx);
            if (check_q[n])
               check_byte({name, " file"}, expect_q[n], rx);
         end
         default:
         begin
            spi_frame(op_q[n], addr_q[n], data_q[n], abort_q[n], rx);   // must change nothing
            spi_read(addr_q[n], rx);                                    // target left alone
            check_byte({name, " ignored"}, model_read(addr_q[n]), rx);
         end
      endcase
   endtask

   // ##############################
   // main sequence
   // ##############################

   initial
   begin
      bit                         file_ok;
      spi_regfile_pkg::reg_byte_t rx;
      int                         n_ignored;
      ss   = 1'b1;                       // held in reset
      mosi = 1'b0;
      void'($urandom(49090));
      load_testdata(file_ok);
      n_ignored = 0;                     // each one adds a readback frame
      foreach (op_q[i])
         if (op_q[i][0])
            n_ignored++;
      cycle_limit = RESET_CYCLES + (op_q.size() + n_ignored + 2 * NUM_REGS) * FRAME_CYCLES + 200;
      limit_ready = 1'b1;
      repeat (RESET_CYCLES) @(posedge sclk);
      #2;
      if (!file_ok)
      begin
         $display("could not open the test data file");
         error_count++;
      end
      else
      begin
         // random fill of every in-range register, then read back
         for (int a = 0; a < NUM_REGS; a++)
         begin
            model[a] = spi_regfile_pkg::reg_byte_t'($urandom());
            spi_write(spi_regfile_pkg::reg_addr_t'(a), model[a], 1'b0);
         end
         for (int a = 0; a < NUM_REGS; a++)
         begin
            spi_read(spi_regfile_pkg::reg_addr_t'(a), rx);
            check_byte($sformatf("fill readback addr %02h", a), model[a], rx);
         end
         for (int n = 0; n < op_q.size(); n++)
            run_entry(n);
      end
      $display("errors: %0d", error_count);
      if (error_count == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- spi_regfile.f
+incdir+include
verilog/spi_regfile_pkg.sv
verilog/spi_slave_io.sv
verilog/spi_reg_bank.sv
verilog/spi_read_select.sv
verilog/spi_regfile_top.sv
verification/tb_spi_regfile.sv

//--- Makefile
# Verilator simulation of the spi register file, run from the project root

TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_spi_regfile
FILELIST = spi_regfile.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- verification/spi_regfile_testdata.txt
# op addr data abort check expect, all hex; op 0 write, 2 read, 1 and 3 ignored codes
# abort 1 raises ss after edge 12; check 1 compares a read with expect, 0 uses the model only
0 00 11 0 0 00
0 07 17 0 0 00
0 08 28 0 0 00
0 0f 2f 0 0 00
0 10 30 0 0 00
0 17 37 0 0 00
0 18 48 0 0 00
0 1f 4f 0 0 00
2 00 00 0 1 11
2 06 00 0 0 00
2 0f 00 0 1 2f
2 18 00 0 1 48
1 0a 0e 0 0 00
3 1f 0f 0 0 00
2 0e 00 0 0 00
2 1f 00 0 1 4f
0 28 ee 0 0 00
2 28 00 0 1 00
2 08 00 0 1 28
0 13 3c 0 0 00
0 13 c3 1 0 00
2 13 00 0 1 3c
0 05 01 0 0 00
2 05 00 0 1 01
